// ==== src/usb_pkg.sv ====
/*
 USB protocol definitions shared by the OUT endpoint receive path.
 CRC values are given in the LSB-first bit order that the bus uses,
 so the register shifts right and bit 0 is the next bit out.
*/
package usb_pkg;

   // One data byte as it comes off the bus
   typedef logic [7:0] usb_byte_t;

   // Running CRC16 register
   typedef logic [15:0] crc16_t;

   // CRC16 of the DATA packets, x^16 + x^15 + x^2 + 1
   // Reflected form, applied when the bit shifted out differs
   // from the incoming data bit
   localparam crc16_t CRC16_POLY = 16'hA001;

   // Value the register holds after a clean packet has been run
   // through it with its two CRC bytes included.
   // The register starts at all ones and the sender complements
   // its CRC, so a good packet does not leave zero behind
   localparam crc16_t CRC16_RESIDUAL = 16'hB001;

   // The CRC bytes follow the payload low byte first.
   // Any payload of n bytes is therefore n+2 strobes long
   // and the shortest valid packet has two strobes

endpackage

// ==== src/out_ep_pkg.sv ====
/*
 Types that travel between the blocks of the OUT endpoint: the byte
 strobe from the packet decoder, the write strobes from the receiver
 into the OUT FIFO, and the state encodings of both blocks.
*/
package out_ep_pkg;

   // Decoded payload byte, data only counts while strobe is high
   typedef struct packed {
      usb_pkg::usb_byte_t data;
      logic               strobe;
   } rx_byte_s;

   // Receiver to FIFO, one event per ready pulse
   //   valid high          write data
   //   err high            abort the packet and roll it back
   //   valid and err low   end of packet, commit it
   typedef struct packed {
      usb_pkg::usb_byte_t data;
      logic               valid;
      logic               err;
      logic               ready;
   } fifo_wr_s;

   // Receiver states, counting how many tail bytes are held back
   typedef enum logic [1:0] {
      IDLE   = 2'd0,
      HOLD1  = 2'd1,
      STREAM = 2'd2,
      DROP   = 2'd3
   } rx_state_e;

   // FIFO write side
   typedef enum logic [1:0] {
      OUT_IDLE = 2'd0,
      OUT_DATA = 2'd1,
      OUT_NAK  = 2'd2
   } fifo_state_e;

endpackage

// ==== src/out_packet_rx.sv ====
/*
 DATA packet receiver of the OUT endpoint. Runs the CRC16 over each
 packet, holds back the two trailing CRC bytes and hands the payload to
 the OUT FIFO as single-cycle write, commit and abort strobes.
*/
module out_packet_rx (
   input  logic                 clk_i,
   input  logic                 rstn_i,
   input  out_ep_pkg::rx_byte_s rx_byte_i,
   input  logic                 rx_eop_i,
   input  logic                 rx_err_i,
   output out_ep_pkg::fifo_wr_s wr_o
);
   import usb_pkg::*;
   import out_ep_pkg::*;

   rx_state_e       state_q;
   crc16_t          crc_q;
   usb_byte_t [1:0] hold_q;
   fifo_wr_s        wr_q;
   logic            take;
   logic            crc_ok;

   // One byte through the reflected CRC16, LSB first
   function automatic crc16_t crc16_next(crc16_t crc, usb_byte_t data);
      crc16_t c;
      c = crc;
      for (int i = 0; i < 8; i++) begin
         if (c[0] ^ data[i]) begin
            c = (c >> 1) ^ CRC16_POLY;
         end else begin
            c = c >> 1;
         end
      end
      return c;
   endfunction

   // Line events take priority over a byte in the same cycle
   assign take = rx_byte_i.strobe && !rx_eop_i && !rx_err_i && (state_q != DROP);

   // Commit needs both CRC bytes seen and a matching residual
   assign crc_ok = (state_q == STREAM) && (crc_q == CRC16_RESIDUAL);

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         state_q <= IDLE;
         crc_q   <= '1;
         wr_q    <= '0;
      end else begin
         wr_q.ready <= 1'b0;
         if (rx_err_i) begin
            // Abort once, then ignore the rest of the packet
            state_q <= DROP;
            crc_q   <= '1;
            if (state_q != DROP) begin
               wr_q.valid <= 1'b0;
               wr_q.err   <= 1'b1;
               wr_q.ready <= 1'b1;
            end
         end else if (rx_eop_i) begin
            state_q <= IDLE;
            crc_q   <= '1;
            // An already aborted packet ends quietly
            if (state_q != DROP) begin
               wr_q.valid <= 1'b0;
               wr_q.err   <= !crc_ok;
               wr_q.ready <= 1'b1;
            end
         end else if (take) begin
            crc_q <= crc16_next(crc_q, rx_byte_i.data);
            case (state_q)
               IDLE: begin
                  state_q <= HOLD1;
               end
               HOLD1: begin
                  state_q <= STREAM;
               end
               default: begin
                  // Two bytes already held, the oldest one is payload
                  wr_q.data  <= hold_q[1];
                  wr_q.valid <= 1'b1;
                  wr_q.err   <= 1'b0;
                  wr_q.ready <= 1'b1;
               end
            endcase
         end
      end
   end

   // Tail of the packet, hold_q[1] is the older byte
   always_ff @(posedge clk_i) begin
      if (take) begin
         hold_q <= {hold_q[0], rx_byte_i.data};
      end
   end

   assign wr_o = wr_q;

   // The FIFO sees at most one event per cycle pair
   a_ready_single : assert property (
      @(posedge clk_i) disable iff (!rstn_i)
      wr_o.ready |=> !wr_o.ready
   ) else $error("wr_o.ready high on two consecutive cycles");

endmodule

// ==== src/out_fifo.sv ====
/*
 OUT endpoint FIFO. Packets are written tentatively and committed or
 rolled back at their end; a packet that meets a full buffer is NAKed
 and dropped. Committed bytes go to the application over valid/ready,
 at most one byte every BIT_SAMPLES clocks.
*/
module out_fifo #(
   parameter int OUT_MAXPACKETSIZE = 8,
   parameter int BIT_SAMPLES       = 4
) (
   input  logic                 clk_i,
   input  logic                 rstn_i,
   input  out_ep_pkg::fifo_wr_s wr_i,
   input  logic                 app_out_ready_i,
   output usb_pkg::usb_byte_t   app_out_data_o,
   output logic                 app_out_valid_o,
   output logic                 out_empty_o,
   output logic                 out_full_o,
   output logic                 out_nak_o
);
   import usb_pkg::*;
   import out_ep_pkg::*;

   // One slot stays free so that full and empty differ
   localparam int OUT_LENGTH = OUT_MAXPACKETSIZE + 1;
   localparam int PTR_W      = (OUT_LENGTH > 1) ? $clog2(OUT_LENGTH) : 1;
   localparam int CNT_W      = (BIT_SAMPLES > 1) ? $clog2(BIT_SAMPLES) : 1;

   typedef logic [PTR_W-1:0] ptr_t;
   typedef logic [CNT_W-1:0] cnt_t;

   localparam ptr_t LAST_IDX = ptr_t'(OUT_LENGTH - 1);
   localparam cnt_t TICK_CNT = cnt_t'(BIT_SAMPLES - 1);

   usb_byte_t   mem_q [OUT_LENGTH];
   ptr_t        rd_q;
   ptr_t        last_q;
   ptr_t        tent_q;
   fifo_state_e state_q;
   logic        nak_q;
   logic        wr_full_q;
   logic        full_q;
   cnt_t        cnt_q;
   logic        wr_en;
   logic        empty;
   logic        tick;
   logic        pop;

   function automatic ptr_t ptr_inc(ptr_t p);
      return (p == LAST_IDX) ? '0 : p + 1'b1;
   endfunction

   function automatic ptr_t ptr_dec(ptr_t p);
      return (p == '0) ? LAST_IDX : p - 1'b1;
   endfunction

   // A byte is stored unless the buffer is full or the packet is NAKed
   assign wr_en = wr_i.ready && wr_i.valid && !wr_i.err &&
                  !wr_full_q && (state_q != OUT_NAK);

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         state_q <= OUT_IDLE;
         last_q  <= '0;
         tent_q  <= '0;
         nak_q   <= 1'b0;
      end else if (wr_i.ready) begin
         if (wr_i.err) begin
            state_q <= OUT_IDLE;
            tent_q  <= last_q;
            nak_q   <= 1'b0;
         end else if (!wr_i.valid) begin
            state_q <= OUT_IDLE;
            // A NAKed packet is thrown away, its first bytes included
            if (nak_q) begin
               tent_q <= last_q;
            end else begin
               last_q <= tent_q;
            end
         end else if (!wr_en) begin
            state_q <= OUT_NAK;
            nak_q   <= 1'b1;
         end else begin
            state_q <= OUT_DATA;
            tent_q  <= ptr_inc(tent_q);
            nak_q   <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem_q[tent_q] <= wr_i.data;
      end
   end

   // Read side, paced to the bit rate
   assign empty = (rd_q == last_q);
   assign tick  = (cnt_q == TICK_CNT);
   assign pop   = tick && !empty && app_out_ready_i;

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         rd_q      <= '0;
         cnt_q     <= '0;
         wr_full_q <= 1'b0;
         full_q    <= 1'b0;
      end else if (!tick) begin
         cnt_q <= cnt_q + 1'b1;
      end else begin
         // Write side checks the tentative pointer, the flag the committed one
         wr_full_q <= (tent_q == ptr_dec(rd_q));
         full_q    <= (last_q == ptr_dec(rd_q));
         if (pop) begin
            cnt_q <= '0;
            rd_q  <= ptr_inc(rd_q);
         end
      end
   end

   assign app_out_valid_o = tick && !empty;
   assign app_out_data_o  = mem_q[rd_q];
   assign out_empty_o     = empty;
   assign out_full_o      = full_q;
   assign out_nak_o       = nak_q;

   // Offered byte holds until the application takes it
   a_out_stable : assert property (
      @(posedge clk_i) disable iff (!rstn_i)
      app_out_valid_o && !app_out_ready_i |=> app_out_valid_o && $stable(app_out_data_o)
   ) else $error("app_out_data_o changed while offered");

   a_full_empty : assert property (
      @(posedge clk_i) disable iff (!rstn_i)
      !(out_full_o && out_empty_o)
   ) else $error("FIFO flagged full and empty at once");

endmodule

// ==== src/usb_out_ep.sv ====
/*
 Receive path of a USB full-speed OUT endpoint. Takes decoded DATA
 payload bytes, checks and strips the CRC16 and buffers good packets
 for the application behind a valid/ready byte stream.
*/
module usb_out_ep #(
   // Payload capacity in bytes
   parameter int OUT_MAXPACKETSIZE = 8,
   // clk_i runs at 12 MHz times this
   parameter int BIT_SAMPLES       = 4
) (
   input  logic                 clk_i,
   input  logic                 rstn_i,
   input  out_ep_pkg::rx_byte_s rx_byte_i,
   input  logic                 rx_eop_i,
   input  logic                 rx_err_i,
   input  logic                 app_out_ready_i,
   output usb_pkg::usb_byte_t   app_out_data_o,
   output logic                 app_out_valid_o,
   output logic                 out_empty_o,
   output logic                 out_full_o,
   output logic                 out_nak_o
);
   import out_ep_pkg::*;

   // Write, commit and abort strobes into the FIFO
   fifo_wr_s wr;

   out_packet_rx i_out_packet_rx (
      .clk_i     (clk_i),
      .rstn_i    (rstn_i),
      .rx_byte_i (rx_byte_i),
      .rx_eop_i  (rx_eop_i),
      .rx_err_i  (rx_err_i),
      .wr_o      (wr)
   );

   out_fifo #(
      .OUT_MAXPACKETSIZE (OUT_MAXPACKETSIZE),
      .BIT_SAMPLES       (BIT_SAMPLES)
   ) i_out_fifo (
      .clk_i           (clk_i),
      .rstn_i          (rstn_i),
      .wr_i            (wr),
      .app_out_ready_i (app_out_ready_i),
      .app_out_data_o  (app_out_data_o),
      .app_out_valid_o (app_out_valid_o),
      .out_empty_o     (out_empty_o),
      .out_full_o      (out_full_o),
      .out_nak_o       (out_nak_o)
   );

endmodule

// ==== verification/out_ep_checker.sv ====
/*
 Checker of the OUT endpoint testbench. Holds the bytes the testbench
 expects, compares every byte the application accepts and watches the
 output pacing and the hold of an offered byte.
*/
module out_ep_checker #(
   parameter int BIT_SAMPLES = 4
) (
   input  logic               clk_i,
   input  logic               rstn_i,
   input  usb_pkg::usb_byte_t app_out_data_i,
   input  logic               app_out_valid_i,
   input  logic               app_out_ready_i,
   input  logic               exp_push_i,
   input  usb_pkg::usb_byte_t exp_data_i,
   output int                 err_cnt_o,
   output int                 pending_o
);
   timeunit 1ns;
   timeprecision 100ps;

   import usb_pkg::*;

   usb_byte_t exp_q [$];
   usb_byte_t held = '0;
   usb_byte_t exp_byte = '0;
   logic      offered = 1'b0;
   logic      seen = 1'b0;
   int        cycle = 0;
   int        last_pop = 0;
   int        err_cnt = 0;
   int        pending = 0;

   always @(posedge clk_i) begin
      if (rstn_i) begin
         cycle = cycle + 1;
         if (exp_push_i) begin
            exp_q.push_back(exp_data_i);
         end
         // Byte offered last cycle and not taken must still be there
         if (offered && !app_out_valid_i) begin
            $display("app_out_valid_o dropped before the offered byte was taken at %0t", $time);
            err_cnt++;
         end else if (offered && (app_out_data_i != held)) begin
            $display("** Error app_out_data_o expected 0x%02h got 0x%02h while offered",
                     held, app_out_data_i);
            err_cnt++;
         end
         offered = app_out_valid_i && !app_out_ready_i;
         held    = app_out_data_i;
         if (app_out_valid_i && app_out_ready_i) begin
            if (seen && ((cycle - last_pop) < BIT_SAMPLES)) begin
               $display("two bytes taken %0d cycles apart, faster than the bit pacing",
                        cycle - last_pop);
               err_cnt++;
            end
            seen     = 1'b1;
            last_pop = cycle;
            if (exp_q.size() == 0) begin
               $display("unexpected byte 0x%02h taken by the application", app_out_data_i);
               err_cnt++;
            end else begin
               exp_byte = exp_q.pop_front();
               if (app_out_data_i !== exp_byte) begin
                  $display("** Error app_out_data_o expected 0x%02h got 0x%02h",
                           exp_byte, app_out_data_i);
                  err_cnt++;
               end
            end
         end
         pending = exp_q.size();
      end
   end

   assign err_cnt_o = err_cnt;
   assign pending_o = pending;

endmodule

// ==== verification/tb_usb_out_ep.sv ====
/*
 Testbench of the USB OUT endpoint receive path. Sends random DATA
 packets with a generated CRC16, drives the application ready and hands
 the bytes it expects to the checker, which compares the output stream.
*/
module tb_usb_out_ep;
   timeunit 1ns;
   timeprecision 100ps;

   import usb_pkg::*;
   import out_ep_pkg::*;

   localparam int          OUT_MAXPACKETSIZE = 8;
   localparam int          BIT_SAMPLES       = 4;
   localparam int          TIMEOUT           = 1000;
   localparam logic [31:0] LFSR_SEED         = 32'h83b570f0;
   // Application ready modes
   localparam int          RDY_LOW           = 0;
   localparam int          RDY_HIGH          = 1;
   localparam int          RDY_RANDOM        = 2;

   logic        clk_i;
   logic        rstn_i;
   rx_byte_s    rx_byte;
   logic        rx_eop;
   logic        rx_err;
   logic        app_out_ready;
   usb_byte_t   app_out_data;
   logic        app_out_valid;
   logic        out_empty;
   logic        out_full;
   logic        out_nak;
   logic        exp_push;
   usb_byte_t   exp_data;
   int          chk_errs;
   int          pending;
   logic [31:0] stim_lfsr;
   logic [31:0] ready_lfsr;
   int          ready_mode;
   usb_byte_t   pkt [OUT_MAXPACKETSIZE];
   usb_byte_t   frame [OUT_MAXPACKETSIZE + 2];
   int          tb_errs;
   int          errs_mark;
   int          test_cnt;
   int          fail_cnt;

   usb_out_ep #(
      .OUT_MAXPACKETSIZE (OUT_MAXPACKETSIZE),
      .BIT_SAMPLES       (BIT_SAMPLES)
   ) i_usb_out_ep (
      .clk_i           (clk_i),
      .rstn_i          (rstn_i),
      .rx_byte_i       (rx_byte),
      .rx_eop_i        (rx_eop),
      .rx_err_i        (rx_err),
      .app_out_ready_i (app_out_ready),
      .app_out_data_o  (app_out_data),
      .app_out_valid_o (app_out_valid),
      .out_empty_o     (out_empty),
      .out_full_o      (out_full),
      .out_nak_o       (out_nak)
   );

   out_ep_checker #(
      .BIT_SAMPLES (BIT_SAMPLES)
   ) i_out_ep_checker (
      .clk_i           (clk_i),
      .rstn_i          (rstn_i),
      .app_out_data_i  (app_out_data),
      .app_out_valid_i (app_out_valid),
      .app_out_ready_i (app_out_ready),
      .exp_push_i      (exp_push),
      .exp_data_i      (exp_data),
      .err_cnt_o       (chk_errs),
      .pending_o       (pending)
   );

   always #20 clk_i = ~clk_i;

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic int rand_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         stim_lfsr = lfsr_next(stim_lfsr);
         v = (v << 1) | int'(stim_lfsr[0]);
      end
      return v;
   endfunction

   // Reflected CRC16, bit 0 of each byte first
   function automatic logic [15:0] crc16_byte(input logic [15:0] crc, input usb_byte_t d);
      logic [15:0] c;
      c = crc;
      for (int i = 0; i < 8; i++) begin
         c = (c[0] ^ d[i]) ? ((c >> 1) ^ CRC16_POLY) : (c >> 1);
      end
      return c;
   endfunction

   always @(negedge clk_i) begin
      if (ready_mode == RDY_RANDOM) begin
         ready_lfsr    = lfsr_next(ready_lfsr);
         app_out_ready = ready_lfsr[0];
      end else begin
         app_out_ready = (ready_mode == RDY_HIGH);
      end
   end

   // One line event for one cycle, then at least one quiet cycle
   task automatic line_event(input logic is_byte, input logic is_eop, input logic is_err,
                             input usb_byte_t b);
      @(negedge clk_i);
      rx_byte.data   = b;
      rx_byte.strobe = is_byte;
      rx_eop         = is_eop;
      rx_err         = is_err;
      @(negedge clk_i);
      rx_byte.strobe = 1'b0;
      rx_eop         = 1'b0;
      rx_err         = 1'b0;
      repeat (rand_bits(2)) @(negedge clk_i);
   endtask

   task automatic make_packet(input int len);
      for (int i = 0; i < len; i++) begin
         pkt[i] = 8'(rand_bits(8));
      end
   endtask

   task automatic expect_packet(input int len);
      for (int i = 0; i < len; i++) begin
         @(negedge clk_i);
         exp_push = 1'b1;
         exp_data = pkt[i];
      end
      @(negedge clk_i);
      exp_push = 1'b0;
   endtask

   // err_at is the strobe index before which rx_err_i fires, -1 for none
   task automatic send_packet(input int len, input bit with_crc, input bit corrupt,
                              input int err_at);
      logic [15:0] crc;
      int          n;
      crc = 16'hffff;
      for (int i = 0; i < len; i++) begin
         frame[i] = pkt[i];
         crc      = crc16_byte(crc, pkt[i]);
      end
      n = len;
      if (with_crc) begin
         // Sent complemented, low byte first
         crc          = ~crc;
         frame[n]     = crc[7:0];
         frame[n + 1] = crc[15:8];
         if (corrupt) begin
            frame[n] = frame[n] ^ 8'(1 << rand_bits(3));
         end
         n = n + 2;
      end
      for (int i = 0; i < n; i++) begin
         if (i == err_at) begin
            line_event(1'b0, 1'b0, 1'b1, '0);
         end
         line_event(1'b1, 1'b0, 1'b0, frame[i]);
      end
      line_event(1'b0, 1'b1, 1'b0, '0);
      repeat (2) @(negedge clk_i);
   endtask

   task automatic wait_empty();
      int n;
      n = 0;
      while (!out_empty && (n < TIMEOUT)) begin
         @(negedge clk_i);
         n++;
      end
      if (!out_empty) begin
         $display("timeout: FIFO still holds data after %0d cycles", TIMEOUT);
         tb_errs++;
      end
      repeat (2) @(negedge clk_i);
   endtask

   task automatic wait_full();
      int n;
      n = 0;
      while (!out_full && (n < TIMEOUT)) begin
         @(negedge clk_i);
         n++;
      end
      if (!out_full) begin
         $display("timeout: FIFO did not report full within %0d cycles", TIMEOUT);
         tb_errs++;
      end
   endtask

   task automatic good_packet(input int len);
      make_packet(len);
      expect_packet(len);
      send_packet(len, 1'b1, 1'b0, -1);
      wait_empty();
   endtask

   task automatic check_flag(input string name, input logic got, input logic want);
      if (got !== want) begin
         $display("** Error %s expected 0x%0h got 0x%0h", name, want, got);
         tb_errs++;
      end
   endtask

   // out_empty_o has to stay high for the whole window
   task automatic check_empty(input int cycles);
      logic bad;
      bad = 1'b0;
      for (int i = 0; i < cycles; i++) begin
         @(negedge clk_i);
         if (!out_empty && !bad) begin
            $display("** Error out_empty_o expected 0x1 got 0x0");
            tb_errs++;
            bad = 1'b1;
         end
      end
   endtask

   task automatic finish_test(input string name);
      int errs;
      if (pending != 0) begin
         $display("%0d expected bytes were never delivered", pending);
         tb_errs++;
      end
      errs      = tb_errs + chk_errs - errs_mark;
      errs_mark = tb_errs + chk_errs;
      test_cnt++;
      if (errs == 0) begin
         $display("test %0d %s: passed", test_cnt, name);
      end else begin
         fail_cnt++;
         $display("test %0d %s: failed with %0d errors", test_cnt, name, errs);
      end
   endtask

   initial begin
      int len;
      clk_i      = 1'b0;
      rstn_i     = 1'b0;
      rx_byte    = '0;
      rx_eop     = 1'b0;
      rx_err     = 1'b0;
      app_out_ready = 1'b0;
      exp_push   = 1'b0;
      exp_data   = '0;
      stim_lfsr  = LFSR_SEED;
      ready_lfsr = LFSR_SEED;
      ready_mode = RDY_LOW;
      tb_errs    = 0;
      errs_mark  = 0;
      test_cnt   = 0;
      fail_cnt   = 0;
      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      rstn_i = 1'b1;
      repeat (4) @(negedge clk_i);

      ready_mode = RDY_RANDOM;
      for (int p = 0; p < 12; p++) begin
         good_packet(rand_bits(4) % (OUT_MAXPACKETSIZE + 1));
      end
      finish_test("good packets");

      // Nothing is drained here, so a wrongly committed byte stays visible
      ready_mode = RDY_LOW;
      repeat (2) @(negedge clk_i);
      for (int p = 0; p < 4; p++) begin
         len = rand_bits(4) % (OUT_MAXPACKETSIZE + 1);
         make_packet(len);
         send_packet(len, 1'b1, 1'b1, -1);
      end
      // Packets of zero and one strobe
      for (int p = 0; p < 2; p++) begin
         make_packet(p);
         send_packet(p, 1'b0, 1'b0, -1);
      end
      check_empty(40);
      finish_test("bad CRC and short packets");

      ready_mode = RDY_RANDOM;
      for (int p = 0; p < 4; p++) begin
         len = 2 + rand_bits(3) % (OUT_MAXPACKETSIZE - 1);
         make_packet(len);
         send_packet(len, 1'b1, 1'b0, 1 + rand_bits(3) % (len + 1));
         good_packet(1 + rand_bits(3) % OUT_MAXPACKETSIZE);
      end
      finish_test("line error then good packet");

      ready_mode = RDY_LOW;
      repeat (2) @(negedge clk_i);
      make_packet(OUT_MAXPACKETSIZE);
      expect_packet(OUT_MAXPACKETSIZE);
      send_packet(OUT_MAXPACKETSIZE, 1'b1, 1'b0, -1);
      wait_full();
      // This one meets a full buffer and is dropped
      make_packet(OUT_MAXPACKETSIZE);
      send_packet(OUT_MAXPACKETSIZE, 1'b1, 1'b0, -1);
      check_flag("out_nak_o", out_nak, 1'b1);
      check_flag("out_full_o", out_full, 1'b1);
      ready_mode = RDY_HIGH;
      wait_empty();
      finish_test("full FIFO and NAK");

      ready_mode = RDY_RANDOM;
      len = 1 + rand_bits(3) % OUT_MAXPACKETSIZE;
      make_packet(len);
      expect_packet(len);
      send_packet(len, 1'b1, 1'b0, -1);
      check_flag("out_nak_o", out_nak, 1'b0);
      wait_empty();
      finish_test("NAK release");

      for (int p = 0; p < 4; p++) begin
         good_packet(OUT_MAXPACKETSIZE);
      end
      finish_test("pacing and hold");

      $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, tb_errs + chk_errs);
      if (fail_cnt == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// ==== usb_out_ep.f ====
src/usb_pkg.sv
src/out_ep_pkg.sv
src/out_packet_rx.sv
src/out_fifo.sv
src/usb_out_ep.sv
verification/out_ep_checker.sv
verification/tb_usb_out_ep.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the OUT endpoint testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --timescale 1ns/100ps -Wno-fatal \
   --top-module tb_usb_out_ep \
   --Mdir obj_dir -o sim_usb_out_ep \
   -f usb_out_ep.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/sim_usb_out_ep)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx 'STATUS: PASS'; then
   exit 0
fi
echo "Simulation did not report a pass"
exit 1
